//--- Makefile
TOP := fire_squeeze_tb
OBJ := obj_dir

.PHONY: all sim lint clean

all: sim

$(OBJ)/V$(TOP): filelist.f verilog/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir $(OBJ)

# Pass only if the log holds the pass line
sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module fire_squeeze

clean:
	rm -rf $(OBJ) sim.log

//--- bench/squeeze_ref.svh
`ifndef SQUEEZE_REF_SVH
`define SQUEEZE_REF_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Q2.14 weight, multiples of 1/16
function automatic int lane_weight(input int lane, input int ch);
	return (((lane * 7 + ch * 3) % 17) - 8) * 1024;
endfunction

// Bias at accumulator scale
function automatic int lane_bias(input int lane);
	return ((lane % 5) - 2) * 65536;
endfunction

// Bias, ReLU, drop 14 fraction bits, clamp to 16 bits
function automatic int requant(input longint sum, input int lane);
	longint biased;
	longint scaled;
	biased = sum + longint'(lane_bias(lane));
	if (biased < 0)
		return 0;
	scaled = biased / 16384;
	if (scaled > 32767)
		return 32767;
	return int'(scaled);
endfunction

// Expected ofm of every lane for the pixel in pix_vals
task automatic queue_expected(input int accept_edge);
	longint sum;
	for (int l = 0; l < DSP_NO; l++) begin
		sum = 0;
		for (int c = 0; c < CHIN; c++)
			sum += longint'(pix_vals[c]) * longint'(lane_weight(l, c));
		exp_q.push_back(requant(sum, l));
	end
	edge_q.push_back(accept_edge);
endtask

// Fixed seed LCG, upper bits returned
function automatic bit [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 8;
endfunction

////////////////////////////////////////////////////////////
// Check helpers
////////////////////////////////////////////////////////////

// Outputs at their reset values
task automatic check_idle();
	assert (!sample) else begin
		$display("Fail sample expected %h got %h", 1'b0, sample);
		errors++;
	end
	assert (!finish) else begin
		$display("Fail finish expected %h got %h", 1'b0, finish);
		errors++;
	end
	for (int l = 0; l < DSP_NO; l++) begin
		assert (ofm[l] == '0) else begin
			$display("Fail ofm[%0d] expected %h got %h", l, 16'h0, ofm[l]);
			errors++;
		end
	end
endtask

// Head of the queue against the sampled ofm
task automatic compare_sample();
	int expected;
	int edge_a;
	edge_a = edge_q.pop_front();
	assert (cycles == edge_a + 2) else begin
		$display("sample at cycle %0d, not two cycles after accept edge %0d", cycles, edge_a);
		errors++;
	end
	for (int l = 0; l < DSP_NO; l++) begin
		expected = exp_q.pop_front();
		assert (ofm[l] == data_t'(expected)) else begin
			$display("Fail ofm[%0d] expected %h got %h", l, data_t'(expected), ofm[l]);
			errors++;
		end
		// Corner cases actually seen
		if (ofm[l] == data_t'(expected) && expected == 32767)
			sat_hits++;
		if (ofm[l] == data_t'(expected) && expected == 0)
			relu_hits++;
	end
endtask

`endif

//--- bench/fire_squeeze_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fire_squeeze_tb;

	import squeeze_pkg::*;

	localparam int DSP_NO = 4;
	localparam int CHIN = 8;
	localparam int WOUT = 3;
	localparam int PIXELS = WOUT * WOUT;

	// Cycle budgets of the six tests
	localparam int BUDGET_RESET = 6;
	localparam int BUDGET_STREAM = 3 * CHIN + 6;
	localparam int BUDGET_GAPS = 3 * CHIN * 4 + 6;
	localparam int BUDGET_EXTREME = 2 * CHIN + 6;
	localparam int BUDGET_FINISH = 2 * CHIN + 16;
	localparam int BUDGET_ACK = 12;
	localparam int CYCLE_LIMIT = 2 * (BUDGET_RESET + BUDGET_STREAM + BUDGET_GAPS
		+ BUDGET_EXTREME + BUDGET_FINISH + BUDGET_ACK);

	logic clk;
	logic arst_n;
	logic squeeze_en;
	data_t ifm;
	logic ram_ack;
	logic sample;
	logic finish;
	data_t ofm [DSP_NO];

	int cycles = 0;
	int errors = 0;
	int tests_passed = 0;
	int samples_seen = 0;
	int sat_hits = 0;
	int relu_hits = 0;
	bit ack_model;
	bit [31:0] lcg_state = 32'h966d;
	int pix_vals [CHIN];
	// Expected lanes, DSP_NO entries per pixel
	int exp_q [$];
	// Edge that accepted each pixel's last channel
	int edge_q [$];

	`include "squeeze_ref.svh"

	fire_squeeze #(
		.DSP_NO(DSP_NO),
		.CHIN(CHIN),
		.WOUT(WOUT)
	) i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.squeeze_en(squeeze_en),
		.ifm(ifm),
		.ram_ack(ram_ack),
		.sample(sample),
		.finish(finish),
		.ofm(ofm)
	);

	always #4 clk = ~clk;

	// Edge counter and run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// Sticky acknowledge as seen by the layer
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ack_model <= 1'b0;
		else if (ram_ack)
			ack_model <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Output monitor, mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (arst_n) begin
			if (sample) begin
				samples_seen++;
				assert (exp_q.size() >= DSP_NO) else begin
					$display("sample at cycle %0d with no expected result queued", cycles);
					errors++;
				end
				if (exp_q.size() >= DSP_NO)
					compare_sample();
			end
			// Done after the last pixel, until acknowledged
			assert (finish == (samples_seen >= PIXELS && !ack_model)) else begin
				$display("Fail finish expected %h got %h",
					samples_seen >= PIXELS && !ack_model, finish);
				errors++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Enable low, junk on ifm
	task automatic drive_idle();
		@(posedge clk);
		#1;
		squeeze_en = 1'b0;
		ifm = data_t'(lcg_next());
	endtask

	// Values within plus or minus 2048
	task automatic fill_random();
		for (int c = 0; c < CHIN; c++)
			pix_vals[c] = int'(lcg_next() % 4097) - 2048;
	endtask

	// One pixel, optional random idle cycles before each channel
	task automatic send_pixel(input int max_gap, input bit counted);
		int gap;
		for (int c = 0; c < CHIN; c++) begin
			gap = (max_gap > 0) ? int'(lcg_next() % (max_gap + 1)) : 0;
			repeat (gap)
				drive_idle();
			@(posedge clk);
			#1;
			squeeze_en = 1'b1;
			ifm = data_t'(pix_vals[c]);
			// Next edge takes the last channel
			if (c == CHIN - 1 && counted)
				queue_expected(cycles + 1);
		end
	endtask

	// Stop the stream and wait for every queued sample
	task automatic wait_drain();
		drive_idle();
		while (exp_q.size() > 0)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	initial begin
		int errs_at;
		int sat_at;
		int relu_at;
		clk = 1'b0;
		arst_n = 1'b0;
		squeeze_en = 1'b0;
		ifm = '0;
		ram_ack = 1'b0;

		// Reset for two rising edges
		errs_at = errors;
		@(negedge clk);
		check_idle();
		@(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		report_test("reset", errs_at);

		// No gaps inside or between pixels
		errs_at = errors;
		repeat (3) begin
			fill_random();
			send_pixel(0, 1'b1);
		end
		wait_drain();
		report_test("back to back", errs_at);

		errs_at = errors;
		repeat (3) begin
			fill_random();
			send_pixel(3, 1'b1);
		end
		wait_drain();
		report_test("random enable", errs_at);

		// Negative pixel, then positive pixel steered at lane 1
		errs_at = errors;
		sat_at = sat_hits;
		relu_at = relu_hits;
		for (int c = 0; c < CHIN; c++)
			pix_vals[c] = -30000;
		send_pixel(0, 1'b1);
		for (int c = 0; c < CHIN; c++)
			pix_vals[c] = (lane_weight(1, c) > 0) ? 32767 : 0;
		send_pixel(0, 1'b1);
		wait_drain();
		assert (sat_hits > sat_at && relu_hits > relu_at) else begin
			$display("saturation or ReLU lane not observed");
			errors++;
		end
		report_test("relu and saturation", errs_at);

		// Ninth pixel ends the layer, later data ignored
		errs_at = errors;
		fill_random();
		send_pixel(0, 1'b1);
		wait_drain();
		assert (finish) else begin
			$display("Fail finish expected %h got %h", 1'b1, finish);
			errors++;
		end
		fill_random();
		send_pixel(0, 1'b0);
		drive_idle();
		repeat (6)
			@(negedge clk);
		report_test("layer finish", errs_at);

		errs_at = errors;
		@(posedge clk);
		#1;
		ram_ack = 1'b1;
		@(posedge clk);
		#1;
		ram_ack = 1'b0;
		repeat (8)
			@(negedge clk);
		assert (!finish) else begin
			$display("Fail finish expected %h got %h", 1'b0, finish);
			errors++;
		end
		report_test("ram ack", errs_at);

		$display("%0d of 6 tests passed, %0d errors", tests_passed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
verilog/squeeze_pkg.sv
verilog/squeeze_sequencer.sv
verilog/squeeze_mac_lane.sv
verilog/squeeze_requant.sv
verilog/fire_squeeze.sv
bench/fire_squeeze_tb.sv

//--- verilog/fire_squeeze.sv
`timescale 1ns/1ps
`default_nettype none

module fire_squeeze #(
	parameter int DSP_NO = 16,
	parameter int CHIN = 64,
	parameter int WOUT = 15
) (
	input wire clk,
	input wire arst_n,
	input wire squeeze_en,
	input wire squeeze_pkg::data_t ifm,
	input wire ram_ack,
	output logic sample,
	output logic finish,
	output squeeze_pkg::data_t ofm [DSP_NO]
);

	import squeeze_pkg::*;

	localparam int CH_W = (CHIN > 1) ? $clog2(CHIN) : 1;

	// Sequencer to lanes
	data_t pix;
	logic [CH_W-1:0] chan;
	logic step;
	logic first;
	// Sequencer to requantizer
	logic group_end;
	// Lane sums gathered for the requantizer
	acc_t lane_acc [DSP_NO];

	////////////////////////////////////////////////////////////
	// Channel sequencer
	////////////////////////////////////////////////////////////

	squeeze_sequencer #(
		.CHIN(CHIN),
		.WOUT(WOUT)
	) i_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.squeeze_en(squeeze_en),
		.ifm(ifm),
		.ram_ack(ram_ack),
		.pix(pix),
		.chan(chan),
		.step(step),
		.first(first),
		.group_end(group_end),
		.finish(finish)
	);

	////////////////////////////////////////////////////////////
	// MAC lane bank
	////////////////////////////////////////////////////////////

	// Each lane owns one output channel
	for (genvar l = 0; l < DSP_NO; l++) begin : g_lane
		squeeze_mac_lane #(
			.LANE(l),
			.CHIN(CHIN)
		) i_lane (
			.clk(clk),
			.arst_n(arst_n),
			.pix(pix),
			.chan(chan),
			.step(step),
			.first(first),
			.acc(lane_acc[l])
		);
	end

	// Bias, ReLU, scaling and output strobe
	squeeze_requant #(
		.DSP_NO(DSP_NO)
	) i_requant (
		.clk(clk),
		.arst_n(arst_n),
		.group_end(group_end),
		.acc(lane_acc),
		.ofm(ofm),
		.sample(sample)
	);

endmodule

`default_nettype wire

//--- verilog/squeeze_mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_mac_lane #(
	parameter int LANE = 0,
	parameter int CHIN = 64,
	localparam int CH_W = (CHIN > 1) ? $clog2(CHIN) : 1
) (
	input wire clk,
	input wire arst_n,
	input wire squeeze_pkg::data_t pix,
	input wire [CH_W-1:0] chan,
	input wire step,
	input wire first,
	output squeeze_pkg::acc_t acc
);

	import squeeze_pkg::*;

	////////////////////////////////////////////////////////////
	// Constant weight column
	////////////////////////////////////////////////////////////

	// One weight per input channel, folded to constants
	data_t weight_col [CHIN];
	data_t weight;
	acc_t product;

	for (genvar c = 0; c < CHIN; c++) begin : g_col
		assign weight_col[c] = weight_of(LANE, c);
	end

	// Channel index selects this cycle's weight
	assign weight = weight_col[chan];

	// Full 32-bit signed product, Q.14 scale
	assign product = acc_t'(pix) * acc_t'(weight);

	////////////////////////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////////////////////////

	// First channel restarts the sum
	// Value holds between steps and after the group ends
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (step) begin
			if (first)
				acc <= product;
			else
				acc <= acc + product;
		end
	end

	// Requantizer reads the sum while the next group loads

endmodule

`default_nettype wire

//--- verilog/squeeze_pkg.sv
`default_nettype none

package squeeze_pkg;

	////////////////////////////////////////////////////////////
	// Fixed point format
	////////////////////////////////////////////////////////////

	// Feature values and weights
	localparam int WIDTH = 16;
	// Lane sums and biases
	localparam int ACC_WIDTH = 32;
	// Weights are Q2.14, also the requant shift
	localparam int FRAC_BITS = 14;

	typedef logic signed [WIDTH-1:0] data_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	////////////////////////////////////////////////////////////
	// Weight and bias generators
	////////////////////////////////////////////////////////////

	// Weight of one lane for one input channel
	// Multiples of 1/16 between -0.5 and +0.5
	function automatic data_t weight_of(input int lane, input int channel);
		int level;
		level = ((lane * 7 + channel * 3) % 17) - 8;
		return data_t'(level * 1024);
	endfunction

	// Per-lane bias, whole units at the accumulator scale
	// 2**16 is four in Q.14
	function automatic acc_t bias_of(input int lane);
		int level;
		level = (lane % 5) - 2;
		return acc_t'(level * 65536);
	endfunction

endpackage

`default_nettype wire

//--- verilog/squeeze_requant.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_requant #(
	parameter int DSP_NO = 16
) (
	input wire clk,
	input wire arst_n,
	input wire group_end,
	input wire squeeze_pkg::acc_t acc [DSP_NO],
	output squeeze_pkg::data_t ofm [DSP_NO],
	output logic sample
);

	import squeeze_pkg::*;

	// Largest positive output value
	localparam acc_t SAT_MAX = acc_t'((1 <<< (WIDTH - 1)) - 1);

	acc_t biased [DSP_NO];
	acc_t shifted [DSP_NO];
	data_t scaled [DSP_NO];

	////////////////////////////////////////////////////////////
	// Bias, ReLU and scaling per lane
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < DSP_NO; i++) begin : g_lane
		assign biased[i] = acc[i] + bias_of(i);
		// Drop the weight fraction
		assign shifted[i] = biased[i] >>> FRAC_BITS;

		always_comb begin
			// ReLU
			if (biased[i] < 0)
				scaled[i] = '0;
			// Clamp at the top of the 16-bit range
			else if (shifted[i] > SAT_MAX)
				scaled[i] = data_t'(SAT_MAX);
			else
				scaled[i] = shifted[i][WIDTH-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////

	// ofm holds until the next group end
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample <= 1'b0;
			for (int i = 0; i < DSP_NO; i++)
				ofm[i] <= '0;
		end else begin
			sample <= group_end;
			if (group_end)
				ofm <= scaled;
		end
	end

endmodule

`default_nettype wire

//--- verilog/squeeze_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_sequencer #(
	parameter int CHIN = 64,
	parameter int WOUT = 15,
	localparam int CH_W = (CHIN > 1) ? $clog2(CHIN) : 1
) (
	input wire clk,
	input wire arst_n,
	input wire squeeze_en,
	input wire squeeze_pkg::data_t ifm,
	input wire ram_ack,
	output squeeze_pkg::data_t pix,
	output logic [CH_W-1:0] chan,
	output logic step,
	output logic first,
	output logic group_end,
	output logic finish
);

	// Pixels in the whole layer
	localparam int PIXELS = WOUT * WOUT;
	localparam int PIX_W = $clog2(PIXELS + 1);
	localparam logic [CH_W-1:0] LAST_CH = CH_W'(CHIN - 1);
	localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(PIXELS - 1);

	logic [CH_W-1:0] ch_cnt;
	logic [PIX_W-1:0] pix_cnt;
	logic done;
	logic ack_seen;
	logic accept;
	logic last_step;

	// One value per enabled edge until the layer ends
	assign accept = squeeze_en && !done;
	// Last channel of a pixel sitting in the pipeline register
	assign last_step = step && (chan == LAST_CH);

	////////////////////////////////////////////////////////////
	// Channel counter and pipeline register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ch_cnt <= '0;
		end else if (accept) begin
			// Wrap after CHIN-1
			if (ch_cnt == LAST_CH)
				ch_cnt <= '0;
			else
				ch_cnt <= ch_cnt + 1'b1;
		end
	end

	// Pixel value rides along with its channel index
	always_ff @(posedge clk) begin
		if (accept)
			pix <= ifm;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chan <= '0;
			step <= 1'b0;
			first <= 1'b0;
			group_end <= 1'b0;
		end else begin
			// Step is a one-cycle pulse per accepted value
			step <= accept;
			if (accept) begin
				chan <= ch_cnt;
				first <= (ch_cnt == '0);
			end
			// Lanes add the last product on this same edge
			group_end <= last_step;
		end
	end

	////////////////////////////////////////////////////////////
	// Layer end and finish handshake
	////////////////////////////////////////////////////////////

	// Counts group_end strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt <= '0;
			done <= 1'b0;
		end else if (group_end) begin
			pix_cnt <= pix_cnt + 1'b1;
			// Strobe of the final pixel closes the layer
			if (pix_cnt == LAST_PIX)
				done <= 1'b1;
		end
	end

	// RAM acknowledge sticks from its first high edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ack_seen <= 1'b0;
		else if (ram_ack)
			ack_seen <= 1'b1;
	end

	assign finish = done && !ack_seen;

endmodule

`default_nettype wire
